// File: Makefile
TOP := connect4_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: build.f
+incdir+hdl
hdl/connect4_pkg.sv
hdl/board_if.sv
hdl/column_stack.sv
hdl/line_scan.sv
hdl/game_status.sv
hdl/connect4_top.sv
verification/connect4_tb.sv

// File: hdl/board_if.sv
`timescale 1ns/1ps
`include "connect4_defines.svh"

interface board_if;

  logic [`C4_ROWS-1:0][`C4_COLS-1:0][1:0] cells; // Row 0 is the bottom
  logic                                   placed;    // Piece landed on the last edge
  logic                                   full_hit;  // Last drop hit a full column
  logic                                   game_over;

  modport stack_mp (
    output cells, placed, full_hit,
    input  game_over
  );

  modport scan_mp (
    input cells
  );

  modport status_mp (
    input  placed, full_hit,
    output game_over
  );

endinterface

// File: hdl/column_stack.sv
`timescale 1ns/1ps
`include "connect4_defines.svh"

module column_stack (
  input  logic                 CLK,
  input  logic                 rst,
  input  logic                 drop,
  input  logic                 player,
  input  logic [`C4_COL_W-1:0] col,
  board_if.stack_mp            bus
);

  localparam int ROW_W = $clog2(`C4_ROWS);
  localparam int H_W   = $clog2(`C4_ROWS + 1);

  logic [`C4_ROWS-1:0][`C4_COLS-1:0][1:0] board;
  logic [`C4_COLS-1:0][H_W-1:0]           heights; // Pieces held per column
  logic [H_W-1:0]                         cur_h;
  logic                                   take;
  logic                                   col_full;
  logic [1:0]                             code;

  // ***************************************************************************
  // Drop decode
  // ***************************************************************************

  assign take     = drop && !bus.game_over; // Drops after game over are lost
  assign cur_h    = heights[col];
  assign col_full = (cur_h == H_W'(`C4_ROWS));
  assign code     = player ? connect4_pkg::CELL_P2 : connect4_pkg::CELL_P1;

  // ***************************************************************************
  // Board and fill heights
  // ***************************************************************************

  always_ff @(posedge CLK) begin
    if (rst) begin
      board        <= '0;
      heights      <= '0;
      bus.placed   <= 1'b0;
      bus.full_hit <= 1'b0;
    end else begin
      bus.placed   <= take && !col_full;
      bus.full_hit <= take && col_full; // Rejected, board untouched
      if (take && !col_full) begin
        board[cur_h[ROW_W-1:0]][col] <= code; // Lands on lowest free row
        heights[col]                 <= cur_h + H_W'(1);
      end
    end
  end

  assign bus.cells = board;

  for (genvar c = 0; c < `C4_COLS; c++) begin : g_height_chk
    a_height_max : assert property (@(posedge CLK) disable iff (rst)
      heights[c] <= H_W'(`C4_ROWS));
  end

endmodule

// File: hdl/connect4_defines.svh
`ifndef CONNECT4_DEFINES_SVH
`define CONNECT4_DEFINES_SVH

// Board geometry
`define C4_ROWS 8
`define C4_COLS 8

// Width of a column index
`define C4_COL_W 3

// Pieces in a winning line
`define C4_WIN_LEN 4

`endif

// File: hdl/connect4_pkg.sv
package connect4_pkg;

  // Cell contents
  localparam logic [1:0] CELL_EMPTY = 2'd0;
  localparam logic [1:0] CELL_P1    = 2'd1;
  localparam logic [1:0] CELL_P2    = 2'd2;

  // Referee status
  localparam logic [1:0] ST_PLAY   = 2'd0;
  localparam logic [1:0] ST_P1_WIN = 2'd1;
  localparam logic [1:0] ST_P2_WIN = 2'd2;
  localparam logic [1:0] ST_FULL   = 2'd3; // Drop into a full column

endpackage

// File: hdl/connect4_top.sv
`timescale 1ns/1ps
`include "connect4_defines.svh"

module connect4_top (
  input  logic                 CLK,
  input  logic                 rst,
  input  logic                 drop,
  input  logic                 player, // 0 is the first player
  input  logic [`C4_COL_W-1:0] col,
  output logic [1:0]           status
);

  logic p1_win;
  logic p2_win;

  board_if board ();

  // ***************************************************************************
  // Storage, scan and referee
  // ***************************************************************************

  column_stack u_stack (
    .CLK    (CLK),
    .rst    (rst),
    .drop   (drop),
    .player (player),
    .col    (col),
    .bus    (board)
  );

  line_scan u_scan (
    .bus    (board),
    .p1_win (p1_win),
    .p2_win (p2_win)
  );

  game_status u_status (
    .CLK    (CLK),
    .rst    (rst),
    .bus    (board),
    .p1_win (p1_win),
    .p2_win (p2_win),
    .status (status)
  );

endmodule

// File: hdl/game_status.sv
`timescale 1ns/1ps

module game_status (
  input  logic       CLK,
  input  logic       rst,
  board_if.status_mp bus,
  input  logic       p1_win,
  input  logic       p2_win,
  output logic [1:0] status
);

  logic [1:0] status_q;

  // ***************************************************************************
  // Status register, sticky once nonzero
  // ***************************************************************************

  always_ff @(posedge CLK) begin
    if (rst) begin
      status_q <= connect4_pkg::ST_PLAY;
    end else if (status_q == connect4_pkg::ST_PLAY) begin
      if (bus.placed) begin
        if (p1_win) begin                        // First player has priority
          status_q <= connect4_pkg::ST_P1_WIN;
        end else if (p2_win) begin
          status_q <= connect4_pkg::ST_P2_WIN;
        end
      end else if (bus.full_hit) begin
        status_q <= connect4_pkg::ST_FULL;
      end
    end
  end

  assign bus.game_over = (status_q != connect4_pkg::ST_PLAY);
  assign status        = status_q;

  a_status_sticky : assert property (@(posedge CLK) disable iff (rst)
    (status_q != connect4_pkg::ST_PLAY) |=> $stable(status_q));

endmodule

// File: hdl/line_scan.sv
`timescale 1ns/1ps
`include "connect4_defines.svh"

module line_scan (
  board_if.scan_mp bus,
  output logic     p1_win,
  output logic     p2_win
);

  localparam int NH = `C4_COLS - `C4_WIN_LEN + 1; // Start columns per row
  localparam int NV = `C4_ROWS - `C4_WIN_LEN + 1; // Start rows per column

  localparam logic [2*`C4_WIN_LEN-1:0] LINE_P1 = {`C4_WIN_LEN{connect4_pkg::CELL_P1}};
  localparam logic [2*`C4_WIN_LEN-1:0] LINE_P2 = {`C4_WIN_LEN{connect4_pkg::CELL_P2}};

  logic [`C4_ROWS*NH-1:0] horz_p1;
  logic [`C4_ROWS*NH-1:0] horz_p2;
  logic [NV*`C4_COLS-1:0] vert_p1;
  logic [NV*`C4_COLS-1:0] vert_p2;
  logic [NV*NH-1:0]       rise_p1;
  logic [NV*NH-1:0]       rise_p2;
  logic [NV*NH-1:0]       fall_p1;
  logic [NV*NH-1:0]       fall_p2;

  // ***************************************************************************
  // Windows of four, one flag per player each
  // ***************************************************************************

  for (genvar r = 0; r < `C4_ROWS; r++) begin : g_horz_row
    for (genvar c = 0; c < NH; c++) begin : g_horz_col
      logic [`C4_WIN_LEN-1:0][1:0] win;
      for (genvar i = 0; i < `C4_WIN_LEN; i++) begin : g_cell
        assign win[i] = bus.cells[r][c+i];
      end
      assign horz_p1[r*NH+c] = (win == LINE_P1);
      assign horz_p2[r*NH+c] = (win == LINE_P2);
    end
  end

  for (genvar r = 0; r < NV; r++) begin : g_vert_row
    for (genvar c = 0; c < `C4_COLS; c++) begin : g_vert_col
      logic [`C4_WIN_LEN-1:0][1:0] win;
      for (genvar i = 0; i < `C4_WIN_LEN; i++) begin : g_cell
        assign win[i] = bus.cells[r+i][c];
      end
      assign vert_p1[r*`C4_COLS+c] = (win == LINE_P1);
      assign vert_p2[r*`C4_COLS+c] = (win == LINE_P2);
    end
  end

  for (genvar r = 0; r < NV; r++) begin : g_rise_row
    for (genvar c = 0; c < NH; c++) begin : g_rise_col
      logic [`C4_WIN_LEN-1:0][1:0] win;
      for (genvar i = 0; i < `C4_WIN_LEN; i++) begin : g_cell
        assign win[i] = bus.cells[r+i][c+i]; // Up and to the right
      end
      assign rise_p1[r*NH+c] = (win == LINE_P1);
      assign rise_p2[r*NH+c] = (win == LINE_P2);
    end
  end

  for (genvar r = 0; r < NV; r++) begin : g_fall_row
    for (genvar c = 0; c < NH; c++) begin : g_fall_col
      logic [`C4_WIN_LEN-1:0][1:0] win;
      for (genvar i = 0; i < `C4_WIN_LEN; i++) begin : g_cell
        assign win[i] = bus.cells[r+`C4_WIN_LEN-1-i][c+i]; // Down and to the right
      end
      assign fall_p1[r*NH+c] = (win == LINE_P1);
      assign fall_p2[r*NH+c] = (win == LINE_P2);
    end
  end

  assign p1_win = |{horz_p1, vert_p1, rise_p1, fall_p1};
  assign p2_win = |{horz_p2, vert_p2, rise_p2, fall_p2};

endmodule

// File: verification/connect4_tb.sv
`timescale 1ns/1ps
`include "connect4_defines.svh"

module connect4_tb;

  localparam logic [31:0] SEED       = 32'h1ea3;
  localparam int          NUM_GAMES  = 40;
  localparam int          MOVE_LIMIT = 100; // Drops per random game
  localparam int          WAIT_LIMIT = 20;  // Cycles to wait for game over

  logic                 CLK;
  logic                 rst;
  logic                 drop;
  logic                 player;
  logic [`C4_COL_W-1:0] col;
  logic [1:0]           status;

  // Reference model state
  logic [1:0] m_board [`C4_ROWS][`C4_COLS];
  int         m_height [`C4_COLS];
  logic [1:0] m_status;
  bit         m_placed;
  bit         m_full;

  logic [31:0] seed;
  int          checks;
  int          errors;
  int          timeouts;
  bit          p;
  int          moves;

  connect4_top DUT (
    .CLK    (CLK),
    .rst    (rst),
    .drop   (drop),
    .player (player),
    .col    (col),
    .status (status)
  );

  always #4 CLK = ~CLK;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // ***************************************************************************
  // Reference model
  // ***************************************************************************

  function automatic bit has_line(input logic [1:0] code);
    bit found;
    int dr;
    int dc;
    int rr;
    int cc;
    int n;
    found = 1'b0;
    for (int r = 0; r < `C4_ROWS; r++) begin
      for (int c = 0; c < `C4_COLS; c++) begin
        for (int d = 0; d < 4; d++) begin
          dr = (d == 0) ? 0 : 1;                       // Row, column, up right, up left
          dc = (d == 1) ? 0 : ((d == 3) ? -1 : 1);
          n  = 0;
          for (int k = 0; k < `C4_WIN_LEN; k++) begin
            rr = r + k * dr;
            cc = c + k * dc;
            if (rr < `C4_ROWS && cc >= 0 && cc < `C4_COLS && m_board[rr][cc] == code) begin
              n++;
            end
          end
          if (n == `C4_WIN_LEN) begin
            found = 1'b1;
          end
        end
      end
    end
    return found;
  endfunction

  task automatic model_clear();
    for (int r = 0; r < `C4_ROWS; r++) begin
      for (int c = 0; c < `C4_COLS; c++) begin
        m_board[r][c] = connect4_pkg::CELL_EMPTY;
      end
    end
    for (int c = 0; c < `C4_COLS; c++) begin
      m_height[c] = 0;
    end
    m_status = connect4_pkg::ST_PLAY;
    m_placed = 1'b0;
    m_full   = 1'b0;
  endtask

  // One rising edge: status from the last event, then this edge's drop
  task automatic model_edge();
    bit over;
    over = (m_status != connect4_pkg::ST_PLAY);
    if (!over) begin
      if (m_placed) begin
        if (has_line(connect4_pkg::CELL_P1)) begin
          m_status = connect4_pkg::ST_P1_WIN;
        end else if (has_line(connect4_pkg::CELL_P2)) begin
          m_status = connect4_pkg::ST_P2_WIN;
        end
      end else if (m_full) begin
        m_status = connect4_pkg::ST_FULL;
      end
    end
    m_placed = 1'b0;
    m_full   = 1'b0;
    if (drop && !over) begin
      if (m_height[col] == `C4_ROWS) begin
        m_full = 1'b1;
      end else begin
        m_board[m_height[col]][col] = player ? connect4_pkg::CELL_P2 : connect4_pkg::CELL_P1;
        m_height[col]++;
        m_placed = 1'b1;
      end
    end
  endtask

  // ***************************************************************************
  // Stimulus and checks
  // ***************************************************************************

  task automatic check_value(input string name, input logic [1:0] exp, input logic [1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected status %0d, actual %0d at %0t", name, exp, act, $time);
    end
  endtask

  // Advance one edge, compare with the model, then drive the next inputs
  task automatic cycle(input bit d, input bit pl, input int c, input string name);
    @(posedge CLK);
    model_edge();
    #1;
    check_value(name, m_status, status);
    drop   = d;
    player = pl;
    col    = `C4_COL_W'(c);
  endtask

  task automatic idle_cycles(input int n, input string name);
    for (int i = 0; i < n; i++) begin
      cycle(1'b0, 1'b0, 0, name);
    end
  endtask

  // Back-to-back drops, players alternating, one digit per column
  task automatic play_moves(input string name, input bit first, input string cols);
    bit pl;
    pl = first;
    for (int i = 0; i < cols.len(); i++) begin
      cycle(1'b1, pl, int'(cols[i] - 8'h30), name);
      pl = !pl;
    end
  endtask

  task automatic wait_game_over(input string name);
    int n;
    n = 0;
    while (status == connect4_pkg::ST_PLAY && n < WAIT_LIMIT) begin
      cycle(1'b0, 1'b0, 0, name);
      n++;
    end
    if (status == connect4_pkg::ST_PLAY) begin
      timeouts++;
      $display("Timeout in %s: status still 0 after %0d cycles", name, WAIT_LIMIT);
    end
  endtask

  task automatic apply_reset();
    rst    = 1'b1;
    drop   = 1'b0;
    player = 1'b0;
    col    = '0;
    repeat (5) @(posedge CLK);
    model_clear();
    #1;
    rst = 1'b0;
  endtask

  initial begin
    CLK      = 1'b0;
    rst      = 1'b1;
    drop     = 1'b0;
    player   = 1'b0;
    col      = '0;
    seed     = SEED;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    model_clear();
    apply_reset();

    idle_cycles(1, "reset");
    check_value("reset", connect4_pkg::ST_PLAY, status);
    play_moves("fill_column", 1'b0, "00000000"); // Alternating, no line
    idle_cycles(2, "fill_column");
    check_value("fill_column", connect4_pkg::ST_PLAY, status);
    play_moves("full_column", 1'b0, "0");
    wait_game_over("full_column");
    check_value("full_column", connect4_pkg::ST_FULL, status);
    play_moves("after_full", 1'b1, "1234");
    idle_cycles(2, "after_full");
    check_value("after_full", connect4_pkg::ST_FULL, status);
    apply_reset();
    idle_cycles(1, "reset_after_full");
    check_value("reset_after_full", connect4_pkg::ST_PLAY, status);

    play_moves("p1_vertical", 1'b0, "2525252");
    idle_cycles(1, "p1_vertical");
    check_value("p1_vertical", connect4_pkg::ST_PLAY, status); // Fourth piece just landed
    idle_cycles(1, "p1_vertical");
    check_value("p1_vertical", connect4_pkg::ST_P1_WIN, status);
    play_moves("after_p1_win", 1'b1, "0000");
    idle_cycles(2, "after_p1_win");
    check_value("after_p1_win", connect4_pkg::ST_P1_WIN, status);
    apply_reset();

    play_moves("p2_horizontal", 1'b0, "01027374");
    wait_game_over("p2_horizontal");
    check_value("p2_horizontal", connect4_pkg::ST_P2_WIN, status);
    apply_reset();
    play_moves("p2_diagonal", 1'b0, "213237434744");
    wait_game_over("p2_diagonal");
    check_value("p2_diagonal", connect4_pkg::ST_P2_WIN, status);

    // ***************************************************************************
    // Random games
    // ***************************************************************************

    for (int g = 0; g < NUM_GAMES; g++) begin
      apply_reset();
      p     = 1'b0;
      moves = 0;
      while (m_status == connect4_pkg::ST_PLAY && moves < MOVE_LIMIT) begin
        seed = lcg_next(seed);
        cycle(1'b1, p, int'(seed[18:16]), "random");
        p = !p;
        moves++;
        if (seed[25:24] == 2'd0) begin
          idle_cycles(1, "random"); // Gap now and then
        end
      end
      if (m_status == connect4_pkg::ST_PLAY) begin
        timeouts++;
        $display("Timeout: random game %0d did not end within %0d drops", g, MOVE_LIMIT);
      end
      play_moves("random_after_end", p, "7");
      idle_cycles(2, "random_after_end");
    end

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
